/* sim.f */
design/mem_bus_pkg.sv
design/cache_geom_pkg.sv
design/frame_array_if.sv
design/frame_store.sv
design/way_lookup.sv
design/cache_ctrl.sv
design/l1_cache.sv
test/l1_cache_chk.sv
test/l1_cache_tb.sv

/* Makefile */
# Verilator build of the L1 cache testbench

.PHONY: run clean

obj_dir/Vl1_cache_tb: sim.f $(shell cat sim.f)
	verilator --binary --timing --assert --top-module l1_cache_tb -f sim.f

run: obj_dir/Vl1_cache_tb
	@out=$$(./obj_dir/Vl1_cache_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir

/* test/l1_cache_tb.sv */
/*
 * Directed testbench for the L1 data cache. A behavioral block memory
 * answers the memory port, and each test task drives the processor port
 * and checks the data, the miss pulses and the memory contents.
 */

`timescale 1ns/10ps
`default_nettype none

module l1_cache_tb
    import mem_bus_pkg::*, cache_geom_pkg::*;
();

    // about 250 cycles of traffic in total, so this leaves wide margin
    localparam int    MAX_CYCLES = 2000;
    localparam word_t FILL_KEY   = 32'h5A5A_5A5A;

    logic     CLK;
    logic     nRST;
    logic     proc_ren;
    logic     proc_wen;
    addr_t    proc_addr;
    word_t    proc_wdata;
    byte_en_t proc_byte_en;
    word_t    proc_rdata;
    logic     proc_busy;
    logic     mem_ren;
    logic     mem_wen;
    addr_t    mem_addr;
    block_t   mem_wdata;
    byte_en_t mem_byte_en;
    block_t   mem_rdata;
    logic     mem_busy;
    logic     flush;
    logic     flush_done;
    logic     cache_miss;

    // memory model, keyed by word address
    word_t    mem_model [addr_t];
    int       busy_cnt = 0;
    logic     busy_next = 1'b1;
    block_t   rdata_next = '0;
    word_t    last_pt_word = '0;
    byte_en_t last_pt_be = '0;

    int    cycles = 0;
    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    miss_count = 0;
    int    ren_count = 0;
    int    done_count = 0;
    word_t rand_state = 32'd69830;

    l1_cache uut (
        .CLK          (CLK),
        .nRST         (nRST),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .proc_byte_en (proc_byte_en),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_byte_en  (mem_byte_en),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy),
        .flush        (flush),
        .flush_done   (flush_done),
        .cache_miss   (cache_miss)
    );

    always #50 CLK = ~CLK;

    function automatic word_t next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    function automatic addr_t make_addr(tag_t tag, set_idx_t set, word_sel_t word);
        return {tag, set, word, 2'b00};
    endfunction

    function automatic word_t merge_bytes(word_t old_d, word_t new_d, byte_en_t be);
        word_t res;
        res = old_d;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_d[8*i +: 8];
            end
        end
        return res;
    endfunction

    // untouched words read back as a function of their address
    function automatic word_t model_read(addr_t a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return a ^ FILL_KEY;
    endfunction

    function automatic void model_write(addr_t a, word_t d, byte_en_t be);
        mem_model[a] = merge_bytes(model_read(a), d, be);
    endfunction

    // uncached transfers carry one word, cached ones a whole block
    task automatic store_transfer();
        addr_t base;
        int    n;
        base = {mem_addr[31:2], 2'b00};
        n = (mem_addr >= NONCACHE_START) ? 1 : WORDS_PER_BLOCK;
        if (n == 1) begin
            last_pt_word = mem_wdata[0];
            last_pt_be   = mem_byte_en;
        end
        for (int w = 0; w < n; w++) begin
            model_write(base + addr_t'(4 * w), mem_wdata[w], mem_byte_en);
        end
    endtask

    function automatic block_t load_transfer();
        block_t blk;
        addr_t  base;
        base = {mem_addr[31:2], 2'b00};
        for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
            blk[w] = model_read(base + addr_t'(4 * w));
        end
        return blk;
    endfunction

    // busy for 3 cycles of a strobe, then low for the cycle that completes it
    always @(negedge CLK) begin
        if (mem_ren || mem_wen) begin
            if (!mem_busy) begin
                if (mem_wen) begin
                    store_transfer();
                end
                busy_next = 1'b1;
                busy_cnt  = 0;
            end else begin
                busy_cnt++;
                if (busy_cnt == 3) begin
                    busy_next  = 1'b0;
                    rdata_next = load_transfer();
                end
            end
        end else begin
            busy_cnt  = 0;
            busy_next = 1'b1;
        end
    end

    always @(posedge CLK) begin
        #1;
        mem_busy  = busy_next;
        mem_rdata = rdata_next;
    end

    // event counters, sampled mid-cycle
    always @(negedge CLK) begin
        if (cache_miss) begin
            miss_count++;
        end
        if (mem_ren) begin
            ren_count++;
        end
        if (flush_done) begin
            done_count++;
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d clock cycles", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_value(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic end_test(string name, int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("[%s] ok", name);
        end else begin
            tests_failed++;
            $display("[%s] %0d check(s) wrong", name, errors - err_before);
        end
    endtask

    // one processor access, entered and left 1 ns after a rising edge
    task automatic access(logic wr, addr_t a, word_t wd, byte_en_t be, output word_t rd);
        proc_ren     = !wr;
        proc_wen     = wr;
        proc_addr    = a;
        proc_wdata   = wd;
        proc_byte_en = be;
        @(negedge CLK);
        while (proc_busy) begin
            @(negedge CLK);
        end
        rd = proc_rdata;
        @(posedge CLK);
        #1;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
    endtask

    task automatic test_read_miss_hit();
        addr_t a;
        word_t rd;
        int    err0;
        int    miss0;
        int    ren0;
        err0  = errors;
        a     = make_addr(26'h10, 3'd1, 1'b1);
        miss0 = miss_count;
        access(1'b0, a, '0, '0, rd);
        check_value("read_miss data", a ^ FILL_KEY, rd);
        check_value("read_miss cache_miss pulses", 1, miss_count - miss0);
        ren0 = ren_count;
        access(1'b0, a, '0, '0, rd);
        check_value("read_hit data", a ^ FILL_KEY, rd);
        check_value("read_hit mem_ren cycles", 0, ren_count - ren0);
        end_test("read miss then hit", err0);
    endtask

    task automatic test_byte_enable_hit();
        addr_t a;
        word_t rd;
        word_t d;
        word_t expected;
        int    err0;
        err0 = errors;
        a    = make_addr(26'h20, 3'd2, 1'b0);
        access(1'b0, a, '0, '0, rd);
        expected = a ^ FILL_KEY;
        d = next_rand();
        access(1'b1, a, d, 4'b0001, rd);
        expected = merge_bytes(expected, d, 4'b0001);
        access(1'b0, a, '0, '0, rd);
        check_value("byte_enable 0001", expected, rd);
        d = next_rand();
        access(1'b1, a, d, 4'b1100, rd);
        expected = merge_bytes(expected, d, 4'b1100);
        access(1'b0, a, '0, '0, rd);
        check_value("byte_enable 1100", expected, rd);
        end_test("byte-enable write hit", err0);
    endtask

    // three tags in one set push the dirty block out
    task automatic test_dirty_eviction();
        addr_t a;
        addr_t b;
        addr_t c;
        word_t d;
        word_t rd;
        int    err0;
        err0 = errors;
        a    = make_addr(26'h30, 3'd3, 1'b0);
        b    = make_addr(26'h31, 3'd3, 1'b0);
        c    = make_addr(26'h32, 3'd3, 1'b1);
        d    = next_rand();
        access(1'b1, a, d, 4'b1111, rd);
        access(1'b0, b, '0, '0, rd);
        access(1'b0, c, '0, '0, rd);
        check_value("dirty_eviction memory word", d, model_read(a));
        access(1'b0, a, '0, '0, rd);
        check_value("dirty_eviction re-read", d, rd);
        end_test("dirty eviction", err0);
    endtask

    task automatic test_pass_through();
        addr_t a;
        word_t d;
        word_t rd;
        int    err0;
        int    miss0;
        err0  = errors;
        a     = 32'hF000_0010;
        d     = next_rand();
        miss0 = miss_count;
        access(1'b1, a, d, 4'b0010, rd);
        check_value("pass_through write word", d & 32'h0000_FF00, last_pt_word);
        check_value("pass_through write enables", 32'h2, word_t'(last_pt_be));
        access(1'b0, a, '0, '0, rd);
        check_value("pass_through read", merge_bytes(a ^ FILL_KEY, d, 4'b0010), rd);
        check_value("pass_through cache_miss pulses", 0, miss_count - miss0);
        end_test("pass-through", err0);
    endtask

    task automatic test_flush();
        addr_t a [4];
        word_t d [4];
        word_t r;
        word_t rd;
        int    err0;
        int    done0;
        int    miss0;
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            r    = next_rand();
            a[i] = make_addr(tag_t'(r[19:0]), set_idx_t'(i + 4), r[23]);
            d[i] = next_rand();
            access(1'b1, a[i], d[i], 4'b1111, rd);
        end
        done0 = done_count;
        flush = 1'b1;
        @(posedge CLK);
        #1;
        flush = 1'b0;
        @(negedge CLK);
        while (!flush_done) begin
            @(negedge CLK);
        end
        // a few idle cycles to catch a stretched done pulse
        repeat (3) begin
            @(posedge CLK);
        end
        #1;
        check_value("flush_done pulses", 1, done_count - done0);
        for (int i = 0; i < 4; i++) begin
            check_value("flush memory word", d[i], model_read(a[i]));
        end
        for (int i = 0; i < 4; i++) begin
            miss0 = miss_count;
            access(1'b0, a[i], '0, '0, rd);
            check_value("flush re-read data", d[i], rd);
            check_value("flush re-read cache_miss pulses", 1, miss_count - miss0);
        end
        end_test("flush", err0);
    endtask

    initial begin
        CLK          = 1'b0;
        nRST         = 1'b0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        flush        = 1'b0;
        mem_busy     = 1'b1;
        mem_rdata    = '0;
        repeat (16) begin
            @(posedge CLK);
        end
        #1;
        nRST = 1'b1;

        test_read_miss_hit();
        test_byte_enable_hit();
        test_dirty_eviction();
        test_pass_through();
        test_flush();

        $display("%0d tests run, %0d failed, %0d wrong values", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/l1_cache_chk.sv */
/*
 * Protocol properties of the cache controller, bound into every
 * cache_ctrl instance.
 */

`timescale 1ns/10ps
`default_nettype none

module l1_cache_chk
    import cache_geom_pkg::*;
(
    input logic         CLK,
    input logic         nRST,
    input logic         mem_ren,
    input logic         mem_wen,
    input logic         flush_done,
    input logic         proc_busy,
    input cache_state_t state
);

    one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else $error("mem_ren and mem_wen high together");

    // done is a single-cycle pulse
    done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else $error("flush_done held for two cycles");

    clear_busy: assert property (@(posedge CLK) disable iff (!nRST)
        (state == CLEAR) |-> proc_busy)
        else $error("proc_busy low during clear");

endmodule

bind cache_ctrl l1_cache_chk u_chk (
    .CLK        (CLK),
    .nRST       (nRST),
    .mem_ren    (mem_ren),
    .mem_wen    (mem_wen),
    .flush_done (flush_done),
    .proc_busy  (proc_busy),
    .state      (state)
);

`default_nettype wire

/* design/l1_cache.sv */
/*
 * L1 data cache top level. Connects the controller, the tag compare and
 * the frame store; the processor and memory buses appear as plain ports.
 */

`timescale 1ns/10ps
`default_nettype none

module l1_cache
    import mem_bus_pkg::*, cache_geom_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     proc_ren,
    input  logic     proc_wen,
    input  addr_t    proc_addr,
    input  word_t    proc_wdata,
    input  byte_en_t proc_byte_en,
    output word_t    proc_rdata,
    output logic     proc_busy,
    output logic     mem_ren,
    output logic     mem_wen,
    output addr_t    mem_addr,
    output block_t   mem_wdata,
    output byte_en_t mem_byte_en,
    input  block_t   mem_rdata,
    input  logic     mem_busy,
    input  logic     flush,
    output logic     flush_done,
    output logic     cache_miss
);

    tag_t     req_tag;
    logic     touch;
    way_idx_t touch_way;
    logic     hit;
    way_idx_t hit_way;
    way_idx_t victim_way;

    frame_array_if arr ();

    frame_store u_store (
        .CLK  (CLK),
        .nRST (nRST),
        .arr  (arr.store)
    );

    way_lookup u_lookup (
        .CLK        (CLK),
        .nRST       (nRST),
        .arr        (arr.ctrl),
        .req_tag    (req_tag),
        .touch      (touch),
        .touch_way  (touch_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    cache_ctrl u_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .proc_byte_en (proc_byte_en),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_byte_en  (mem_byte_en),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy),
        .flush        (flush),
        .flush_done   (flush_done),
        .cache_miss   (cache_miss),
        .arr          (arr.ctrl),
        .req_tag      (req_tag),
        .touch        (touch),
        .touch_way    (touch_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way)
    );

endmodule

`default_nettype wire

/* design/cache_ctrl.sv */
/*
 * Cache controller. Serves hits in the request cycle, runs block fetch,
 * victim writeback, the post-reset clear and the flush walk, and passes
 * uncached addresses straight to memory.
 */

`timescale 1ns/10ps
`default_nettype none

module cache_ctrl
    import mem_bus_pkg::*, cache_geom_pkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    input  logic                proc_ren,
    input  logic                proc_wen,
    input  addr_t               proc_addr,
    input  word_t               proc_wdata,
    input  byte_en_t            proc_byte_en,
    output word_t               proc_rdata,
    output logic                proc_busy,
    output logic                mem_ren,
    output logic                mem_wen,
    output addr_t               mem_addr,
    output block_t              mem_wdata,
    output byte_en_t            mem_byte_en,
    input  block_t              mem_rdata,
    input  logic                mem_busy,
    input  logic                flush,
    output logic                flush_done,
    output logic                cache_miss,
    frame_array_if.ctrl         arr,
    output tag_t                req_tag,
    output logic                touch,
    output way_idx_t            touch_way,
    input  logic                hit,
    input  way_idx_t            hit_way,
    input  way_idx_t            victim_way
);

    cache_state_t state, next_state;
    clear_idx_t   cidx, next_cidx, cidx_step;
    logic         flush_req;
    addr_fields_t dec;
    logic         pass_through;
    logic         req;
    word_t        lane_bits;
    frame_t       victim_frame;
    frame_t       walk_frame;
    frame_t       fill_frame;

    function automatic addr_t block_addr(tag_t tag, set_idx_t idx);
        return {tag, idx, {BLOCK_BITS{1'b0}}, {OFFSET_BITS{1'b0}}};
    endfunction

    assign dec          = addr_fields_t'(proc_addr);
    assign pass_through = proc_addr >= NONCACHE_START;
    assign req          = proc_ren | proc_wen;
    assign req_tag      = dec.tag;
    assign touch_way    = hit_way;
    assign cidx_step    = clear_idx_t'(cidx + 1);

    // clear and flush walk the frames, everything else follows the request
    assign arr.sel = (state == CLEAR || state == FLUSH) ? cidx.idx : dec.idx;

    assign victim_frame = arr.rrow[victim_way];
    assign walk_frame   = arr.rrow[cidx.way];

    // byte enables widened to bit lanes
    always_comb begin
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            lane_bits[8*i +: 8] = {8{proc_byte_en[i]}};
        end
    end

    // refilled frame, with a write miss merged into its word
    always_comb begin
        fill_frame.tag.valid = 1'b1;
        fill_frame.tag.dirty = proc_wen;
        fill_frame.tag.tag   = dec.tag;
        fill_frame.data      = mem_rdata;
        if (proc_wen) begin
            fill_frame.data[dec.word] = (mem_rdata[dec.word] & ~lane_bits)
                                      | (proc_wdata & lane_bits);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= CLEAR;
            cidx      <= '0;
            flush_req <= 1'b0;
        end else begin
            state <= next_state;
            cidx  <= next_cidx;
            if (flush_done) begin
                flush_req <= 1'b0;
            end else if (flush) begin
                flush_req <= 1'b1;
            end
        end
    end

    always_comb begin
        next_state  = state;
        next_cidx   = cidx;
        arr.wen     = 1'b0;
        arr.wrow    = '0;
        arr.wmask   = '1;
        proc_busy   = 1'b1;
        proc_rdata  = '0;
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_addr    = block_addr(dec.tag, dec.idx);
        mem_wdata   = '0;
        mem_byte_en = '1;
        flush_done  = 1'b0;
        cache_miss  = 1'b0;
        touch       = 1'b0;

        case (state)
            CLEAR: begin
                if (cidx.finish) begin
                    next_cidx  = '0;
                    next_state = READY;
                end else begin
                    arr.wen              = 1'b1;
                    arr.wmask[cidx.way]  = '0;
                    next_cidx            = cidx_step;
                end
            end
            READY: begin
                if (flush || flush_req) begin
                    next_state = FLUSH;
                end else if (pass_through) begin
                    mem_ren      = proc_ren;
                    mem_wen      = proc_wen;
                    mem_addr     = proc_addr;
                    mem_byte_en  = proc_byte_en;
                    mem_wdata[0] = proc_wdata & lane_bits;
                    proc_rdata   = mem_rdata[0];
                    proc_busy    = mem_busy;
                end else if (req && hit) begin
                    proc_busy  = 1'b0;
                    touch      = 1'b1;
                    proc_rdata = arr.rrow[hit_way].data[dec.word];
                    if (proc_wen) begin
                        arr.wen                           = 1'b1;
                        arr.wrow[hit_way].data[dec.word]  = proc_wdata;
                        arr.wmask[hit_way].data[dec.word] = ~lane_bits;
                        arr.wrow[hit_way].tag.dirty       = 1'b1;
                        arr.wmask[hit_way].tag.dirty      = 1'b0;
                    end
                end else if (req) begin
                    // dirty victim has to go out before the fetch
                    if (victim_frame.tag.valid && victim_frame.tag.dirty) begin
                        next_state = WRITEBACK;
                    end else begin
                        next_state = FETCH;
                    end
                end
            end
            FETCH: begin
                mem_ren = 1'b1;
                if (!mem_busy) begin
                    cache_miss            = 1'b1;
                    arr.wen               = 1'b1;
                    arr.wrow[victim_way]  = fill_frame;
                    arr.wmask[victim_way] = '0;
                    next_state            = READY;
                end
            end
            WRITEBACK: begin
                mem_wen   = 1'b1;
                mem_addr  = block_addr(victim_frame.tag.tag, dec.idx);
                mem_wdata = victim_frame.data;
                if (!mem_busy) begin
                    // wrow is zero here, so this drops valid and dirty
                    arr.wen                         = 1'b1;
                    arr.wmask[victim_way].tag.valid = 1'b0;
                    arr.wmask[victim_way].tag.dirty = 1'b0;
                    next_state                      = READY;
                end
            end
            FLUSH: begin
                if (cidx.finish) begin
                    flush_done = 1'b1;
                    next_cidx  = '0;
                    next_state = READY;
                end else if (walk_frame.tag.valid && walk_frame.tag.dirty) begin
                    mem_wen   = 1'b1;
                    mem_addr  = block_addr(walk_frame.tag.tag, cidx.idx);
                    mem_wdata = walk_frame.data;
                    if (!mem_busy) begin
                        arr.wen             = 1'b1;
                        arr.wmask[cidx.way] = '0;
                        next_cidx           = cidx_step;
                    end
                end else begin
                    // clean or empty, just clear it
                    arr.wen             = 1'b1;
                    arr.wmask[cidx.way] = '0;
                    next_cidx           = cidx_step;
                end
            end
            default: begin
                next_state = CLEAR;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/way_lookup.sv */
/*
 * Tag compare over the selected row and a one-bit last-used record per
 * set. The way not used last is offered as the replacement victim.
 */

`timescale 1ns/10ps
`default_nettype none

module way_lookup
    import cache_geom_pkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    frame_array_if.ctrl         arr,
    input  tag_t                req_tag,
    input  logic                touch,
    input  way_idx_t            touch_way,
    output logic                hit,
    output way_idx_t            hit_way,
    output way_idx_t            victim_way
);

    logic [N_SETS-1:0] last_used;

    // only valid frames can match
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            if (arr.rrow[w].tag.valid && arr.rrow[w].tag.tag == req_tag) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            last_used <= '0;
        end else if (touch) begin
            last_used[arr.sel] <= touch_way;
        end
    end

    // two ways, so the victim is simply the other one
    assign victim_way = way_idx_t'(~last_used[arr.sel]);

endmodule

`default_nettype wire

/* design/frame_store.sv */
/*
 * Tag and data storage for both ways, one row per set.
 * Read is combinational on the select; writes land on the clock edge.
 */

`timescale 1ns/10ps
`default_nettype none

module frame_store
    import cache_geom_pkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    frame_array_if.store        arr
);

    set_row_t rows [N_SETS];
    set_row_t merged;

    // keep masked bits, take the rest from the write row
    assign merged = (rows[arr.sel] & arr.wmask) | (arr.wrow & ~arr.wmask);

    // writes held off while reset is asserted
    always_ff @(posedge CLK) begin
        if (nRST && arr.wen) begin
            rows[arr.sel] <= merged;
        end
    end

    assign arr.rrow = rows[arr.sel];

endmodule

`default_nettype wire

/* design/frame_array_if.sv */
/*
 * Row access to the frame store. The controller selects a set and may
 * write it under a bit mask; the store returns the selected row.
 */

`timescale 1ns/10ps
`default_nettype none

interface frame_array_if
    import cache_geom_pkg::*;
();

    set_idx_t sel;
    logic     wen;
    set_row_t wrow;
    // a 0 bit lets the matching wrow bit through
    set_row_t wmask;
    set_row_t rrow;

    modport ctrl (
        output sel, wen, wrow, wmask,
        input  rrow
    );

    modport store (
        input  sel, wen, wrow, wmask,
        output rrow
    );

endinterface

`default_nettype wire

/* design/cache_geom_pkg.sv */
/*
 * Geometry of the 2-way data cache, address field split, frame layout
 * and the controller state encoding.
 */

`default_nettype none

package cache_geom_pkg;

    import mem_bus_pkg::*;

    localparam int N_SETS      = 8;
    localparam int N_WAYS      = 2;
    localparam int SET_BITS    = $clog2(N_SETS);
    localparam int BLOCK_BITS  = $clog2(WORDS_PER_BLOCK);
    localparam int OFFSET_BITS = $clog2(BYTES_PER_WORD);
    localparam int TAG_BITS    = ADDR_BITS - SET_BITS - BLOCK_BITS - OFFSET_BITS;

    typedef logic [SET_BITS-1:0]        set_idx_t;
    typedef logic [$clog2(N_WAYS)-1:0]  way_idx_t;
    typedef logic [BLOCK_BITS-1:0]      word_sel_t;
    typedef logic [TAG_BITS-1:0]        tag_t;

    // processor address as seen by the cache
    typedef struct packed {
        tag_t                   tag;
        set_idx_t               idx;
        word_sel_t              word;
        logic [OFFSET_BITS-1:0] offset;
    } addr_fields_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        tag_entry_t tag;
        block_t     data;
    } frame_t;

    typedef frame_t [N_WAYS-1:0] set_row_t;

    // walks every frame; way in the low bits, so +1 steps way first
    typedef struct packed {
        logic     finish;
        set_idx_t idx;
        way_idx_t way;
    } clear_idx_t;

    typedef enum logic [2:0] {
        CLEAR,
        READY,
        FETCH,
        WRITEBACK,
        FLUSH
    } cache_state_t;

endpackage

`default_nettype wire

/* design/mem_bus_pkg.sv */
/*
 * Word, address and block types shared by the processor and memory ports.
 * Import wherever a bus-side signal is declared.
 */

`default_nettype none

package mem_bus_pkg;

    localparam int WORD_BITS      = 32;
    localparam int ADDR_BITS      = 32;
    localparam int BYTES_PER_WORD = WORD_BITS / 8;

    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [ADDR_BITS-1:0]      addr_t;
    typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

    // memory side always moves a whole block
    localparam int WORDS_PER_BLOCK = 2;
    typedef word_t [WORDS_PER_BLOCK-1:0] block_t;

    // everything from here up bypasses the cache
    localparam addr_t NONCACHE_START = 32'hF000_0000;

endpackage

`default_nettype wire
